// File: dv/blockGame_sva.sv
`timescale 1ns/100ps
`default_nettype none

module blockGame_sva (
    input logic clk,
    input logic arstN,
    input logic spawnReq,
    input logic spawnAck,
    input logic pieceLocked
);

    int assertFails = 0;

    // ack only answers a live request
    property ackNeedsReq;
        @(posedge clk) disable iff (!arstN)
            $rose(spawnAck) |-> $past(spawnReq);
    endproperty

    property ackFollowsReqDown;
        @(posedge clk) disable iff (!arstN)
            $fell(spawnReq) |-> ##[0:2] !spawnAck;
    endproperty

    // lock is a single-cycle pulse
    property lockIsPulse;
        @(posedge clk) disable iff (!arstN)
            pieceLocked |=> !pieceLocked;
    endproperty

    assert property (ackNeedsReq)
        else begin
            assertFails++;
            $error("spawnAck rose while spawnReq was low");
        end
    assert property (ackFollowsReqDown)
        else begin
            assertFails++;
            $error("spawnAck still high two cycles after spawnReq fell");
        end
    assert property (lockIsPulse)
        else begin
            assertFails++;
            $error("pieceLocked high for two cycles in a row");
        end

endmodule

`default_nettype wire

// File: dv/blockGame_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "blocks_params.svh"

module blockGame_tb;

    localparam int clkPeriod = 40;
    localparam int resetCycles = 8;
    localparam int spawnCount = 40;
    localparam int cyclesPerSpawn = 200;
    localparam int ackLatency = 7;

    logic clk;
    logic arstN;
    logic left;
    logic right;
    logic spawnReq;
    logic spawnAck;
    logic pieceLocked;
    blocks_pkg::colorRow colorValues [0:`BOARD_ROWS-1];

    integer seed;
    int valueErrors;
    int timeoutErrors;
    int lockCount;
    logic checking;

    // playfield model
    logic mOcc [0:`BOARD_ROWS-1][0:`BOARD_COLS-1];
    logic sOcc [0:`BOARD_ROWS-1][0:`BOARD_COLS-1];
    logic landed [0:`BOARD_ROWS-1][0:`BOARD_COLS-1];
    blocks_pkg::cellCode sCode [0:`BOARD_ROWS-1][0:`BOARD_COLS-1];
    blocks_pkg::cellCode mType;
    blocks_pkg::cellCode nextType;
    logic mLeftQ;
    logic mRightQ;
    logic mLeftLatch;
    logic mRightLatch;
    logic mAck;
    logic mLocked;
    logic mBusy;
    int mStage;
    int edgeCount;

    blockGame dut_i (
        .clk         (clk),
        .arstN       (arstN),
        .left        (left),
        .right       (right),
        .spawnReq    (spawnReq),
        .spawnAck    (spawnAck),
        .pieceLocked (pieceLocked),
        .colorValues (colorValues)
    );

    bind blockGame blockGame_sva sva_i (
        .clk         (clk),
        .arstN       (arstN),
        .spawnReq    (spawnReq),
        .spawnAck    (spawnAck),
        .pieceLocked (pieceLocked)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // tetromino rows top to bottom, bit 3 leftmost
    function automatic blocks_pkg::shapeRow shapeOf(input blocks_pkg::cellCode kind,
                                                    input int row);
        logic [15:0] rows;
        case (kind)
            4'd1: rows = 16'hE400;
            4'd2: rows = 16'h6600;
            4'd3: rows = 16'h8E00;
            4'd4: rows = 16'h2E00;
            4'd5: rows = 16'hC600;
            4'd6: rows = 16'h6C00;
            4'd7: rows = 16'hF000;
            default: rows = 16'h0000;
        endcase
        return rows[15 - 4 * row -: 4];
    endfunction

    function automatic blocks_pkg::pixelColor colorOf(input blocks_pkg::cellCode code);
        case (code)
            4'd1: return 8'hA2;
            4'd2: return 8'hFC;
            4'd3: return 8'h03;
            4'd4: return 8'hF0;
            4'd5: return 8'hE0;
            4'd6: return 8'h1C;
            4'd7: return 8'h1F;
            4'd8: return 8'h92;
            default: return 8'h00;
        endcase
    endfunction

    task automatic checkColorRow(input int row, input blocks_pkg::colorRow expected,
                                 input blocks_pkg::colorRow actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED t=%0t colorValues[%0d] expected=%h actual=%h",
                     $time, row, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            valueErrors++;
            $display("FAILED t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
        end
    endtask

    always @(posedge clk) begin : modelStep
        logic placeNow;
        logic tickNow;
        logic moveOk;
        logic lockNow;
        int dc;
        blocks_pkg::shapeRow rowBits;
        if (!arstN) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                for (int c = 0; c < `BOARD_COLS; c++) begin
                    mOcc[r][c] = 1'b0;
                    sOcc[r][c] = 1'b0;
                    sCode[r][c] = 4'd0;
                end
            end
            mType = 4'd0;
            nextType = 4'd1;
            mLeftQ = 1'b0;
            mRightQ = 1'b0;
            mLeftLatch = 1'b0;
            mRightLatch = 1'b0;
            mAck = 1'b0;
            mLocked = 1'b0;
            mBusy = 1'b0;
            mStage = 0;
            edgeCount = 0;
        end else begin
            edgeCount++;
            placeNow = 1'b0;
            // request taken in idle, piece placed and acked six edges later
            if (!mBusy) begin
                if (spawnReq) begin
                    mBusy = 1'b1;
                    mStage = 0;
                end
            end else if (mStage < 6) begin
                mStage++;
                placeNow = (mStage == 6);
            end else if (!spawnReq) begin
                mAck = 1'b0;
                mBusy = 1'b0;
            end
            tickNow = !placeNow && edgeCount > 1 && (edgeCount - 1) % `DROP_PERIOD == 0;
            mLocked = 1'b0;
            if (placeNow) begin
                mAck = 1'b1;
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    for (int c = 0; c < `BOARD_COLS; c++) begin
                        mOcc[r][c] = 1'b0;
                    end
                end
                for (int r = 0; r < 4; r++) begin
                    rowBits = shapeOf(nextType, r);
                    for (int k = 0; k < 4; k++) begin
                        mOcc[r][`SPAWN_COL + k] = rowBits[3 - k];
                    end
                end
                mType = nextType;
                nextType = (nextType == 4'd7) ? 4'd1 : nextType + 4'd1;
            end else if (tickNow) begin
                dc = 0;
                if (mLeftLatch && !mRightLatch) begin
                    dc = -1;
                end else if (mRightLatch && !mLeftLatch) begin
                    dc = 1;
                end
                moveOk = (dc != 0);
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    for (int c = 0; c < `BOARD_COLS; c++) begin
                        if (mOcc[r][c]) begin
                            if (c + dc < 0 || c + dc >= `BOARD_COLS) begin
                                moveOk = 1'b0;
                            end else if (sOcc[r][c + dc]) begin
                                moveOk = 1'b0;
                            end
                        end
                        landed[r][c] = 1'b0;
                    end
                end
                if (!moveOk) begin
                    dc = 0;
                end
                lockNow = 1'b0;
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    for (int c = 0; c < `BOARD_COLS; c++) begin
                        if (mOcc[r][c]) begin
                            landed[r][c + dc] = 1'b1;
                            if (r == `BOARD_ROWS - 1 || sOcc[r + 1][c + dc]) begin
                                lockNow = 1'b1;
                            end
                        end
                    end
                end
                for (int r = `BOARD_ROWS - 1; r >= 0; r--) begin
                    for (int c = 0; c < `BOARD_COLS; c++) begin
                        if (lockNow) begin
                            if (landed[r][c]) begin
                                sOcc[r][c] = 1'b1;
                                sCode[r][c] = mType;
                            end
                            mOcc[r][c] = 1'b0;
                        end else begin
                            mOcc[r][c] = (r > 0) ? landed[r - 1][c] : 1'b0;
                        end
                    end
                end
                mLocked = lockNow;
            end
            if (tickNow) begin
                mLeftLatch = 1'b0;
                mRightLatch = 1'b0;
            end
            if (left && !mLeftQ) begin
                mLeftLatch = 1'b1;
            end
            if (right && !mRightQ) begin
                mRightLatch = 1'b1;
            end
            mLeftQ = left;
            mRightQ = right;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compareStep
        blocks_pkg::colorRow expRow;
        blocks_pkg::cellCode code;
        if (checking) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                for (int c = 0; c < `BOARD_COLS; c++) begin
                    code = (mOcc[r][c] ? mType : 4'd0) | (sOcc[r][c] ? sCode[r][c] : 4'd0);
                    expRow[c] = colorOf(code);
                end
                checkColorRow(r, expRow, colorValues[r]);
            end
            checkBit("spawnAck", mAck, spawnAck);
            checkBit("pieceLocked", mLocked, pieceLocked);
            if (pieceLocked === 1'b1) begin
                lockCount++;
            end
        end
    end

    initial begin : buttonStim
        int hold;
        logic [31:0] draw;
        @(posedge arstN);
        forever begin
            hold = ($unsigned($random(seed)) % 12) + 1;
            repeat (hold) @(posedge clk);
            #2;
            draw = $random(seed);
            left = draw[0];
            right = draw[1];
        end
    end

    initial begin : mainSeq
        int gap;
        int waited;
        int locksBefore;
        seed = 32'he0e1_6d6f;
        clk = 1'b0;
        arstN = 1'b0;
        left = 1'b0;
        right = 1'b0;
        spawnReq = 1'b0;
        checking = 1'b0;
        valueErrors = 0;
        timeoutErrors = 0;
        lockCount = 0;
        repeat (resetCycles) @(posedge clk);
        #2;
        arstN = 1'b1;
        checking = 1'b1;
        for (int n = 0; n < spawnCount && timeoutErrors == 0; n++) begin
            gap = $unsigned($random(seed)) % 61;
            repeat (gap) begin
                @(posedge clk);
                #2;
            end
            // steer one placement onto a drop tick
            if (n == 1) begin
                while ((edgeCount + 6) % `DROP_PERIOD != 0) begin
                    @(posedge clk);
                    #2;
                end
            end
            spawnReq = 1'b1;
            waited = 0;
            while (!spawnAck && waited < 20) begin
                @(posedge clk);
                #2;
                waited++;
            end
            locksBefore = lockCount;
            if (!spawnAck) begin
                timeoutErrors++;
                $display("spawnAck did not rise within 20 cycles of spawnReq at t=%0t", $time);
            end else if (waited != ackLatency) begin
                valueErrors++;
                $display("FAILED t=%0t spawnAck latency expected=%0d actual=%0d",
                         $time, ackLatency, waited);
            end
            spawnReq = 1'b0;
            waited = 0;
            while (spawnAck && waited < 20) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (spawnAck) begin
                timeoutErrors++;
                $display("spawnAck stayed high after spawnReq fell at t=%0t", $time);
            end
            // let every fourth piece come to rest
            if (n % 4 == 3) begin
                waited = 0;
                while (lockCount == locksBefore && waited < 160) begin
                    @(posedge clk);
                    #2;
                    waited++;
                end
                if (lockCount == locksBefore) begin
                    timeoutErrors++;
                    $display("no piece locked within 160 cycles at t=%0t", $time);
                end
            end
        end
        repeat (4 * `DROP_PERIOD) @(posedge clk);
        $display("errors: %0d value mismatches, %0d timeouts, %0d assertion failures (%0d locks seen)",
                 valueErrors, timeoutErrors, dut_i.sva_i.assertFails, lockCount);
        if (valueErrors == 0 && timeoutErrors == 0 && dut_i.sva_i.assertFails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((resetCycles + spawnCount * cyclesPerSpawn) * clkPeriod);
        $display("watchdog expired, run did not finish within %0d cycles",
                 resetCycles + spawnCount * cyclesPerSpawn);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/blocks_pkg.sv
verilog/shapeRom.sv
verilog/dropTicker.sv
verilog/pieceFetcher.sv
verilog/boardEngine.sv
verilog/cellColorizer.sv
verilog/blockGame.sv
dv/blockGame_sva.sv
dv/blockGame_tb.sv

// File: verilog/blockGame.sv
`timescale 1ns/100ps
`default_nettype none

`include "blocks_params.svh"

module blockGame (
    input  logic                clk,
    input  logic                arstN,
    input  logic                left,
    input  logic                right,
    input  logic                spawnReq,
    output logic                spawnAck,
    output logic                pieceLocked,
    output blocks_pkg::colorRow colorValues [0:`BOARD_ROWS-1]
);

    logic [4:0]                romAddr;
    blocks_pkg::shapeRow       romData;
    logic                      dropTick;
    logic                      placeStrobe;
    blocks_pkg::cellCode       placeType;
    blocks_pkg::shapeRow [0:3] placeShape;
    blocks_pkg::boardRow       fullBoard [0:`BOARD_ROWS-1];

    shapeRom rom (
        .clk     (clk),
        .romAddr (romAddr),
        .romData (romData)
    );

    dropTicker ticker (
        .clk      (clk),
        .arstN    (arstN),
        .dropTick (dropTick)
    );

    pieceFetcher fetcher (
        .clk         (clk),
        .arstN       (arstN),
        .spawnReq    (spawnReq),
        .spawnAck    (spawnAck),
        .romAddr     (romAddr),
        .romData     (romData),
        .placeStrobe (placeStrobe),
        .placeType   (placeType),
        .placeShape  (placeShape)
    );

    boardEngine engine (
        .clk         (clk),
        .arstN       (arstN),
        .left        (left),
        .right       (right),
        .dropTick    (dropTick),
        .placeStrobe (placeStrobe),
        .placeType   (placeType),
        .placeShape  (placeShape),
        .pieceLocked (pieceLocked),
        .fullBoard   (fullBoard)
    );

    cellColorizer colorizer (
        .fullBoard   (fullBoard),
        .colorValues (colorValues)
    );

endmodule

`default_nettype wire

// File: verilog/blocks_params.svh
`ifndef BLOCKS_PARAMS_SVH
`define BLOCKS_PARAMS_SVH

// playfield size, row 0 at the top and column 0 at the left
`define BOARD_ROWS 12
`define BOARD_COLS 10

// cycles between drop ticks
`define DROP_PERIOD 8

// leftmost column of the 4-wide spawn window
`define SPAWN_COL 3

`endif

// File: verilog/blocks_pkg.sv
`default_nettype none

`include "blocks_params.svh"

package blocks_pkg;

    // 0 is empty, 1 to 7 give the piece type
    typedef logic [3:0] cellCode;

    // bit 3 is the leftmost column of the window
    typedef logic [3:0] shapeRow;

    typedef cellCode [0:`BOARD_COLS-1] boardRow;

    // RGB332
    typedef logic [7:0] pixelColor;

    typedef pixelColor [0:`BOARD_COLS-1] colorRow;

    typedef enum logic [1:0] {
        idle,
        readRows,
        place,
        acked
    } fetchState;

    // black, T, O, J, L, Z, S, I, spare gray
    localparam pixelColor pieceColors [0:8] = '{
        8'h00, 8'hA2, 8'hFC, 8'h03, 8'hF0, 8'hE0, 8'h1C, 8'h1F, 8'h92
    };

endpackage

`default_nettype wire

// File: verilog/boardEngine.sv
`timescale 1ns/100ps
`default_nettype none

`include "blocks_params.svh"

module boardEngine (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      left,
    input  logic                      right,
    input  logic                      dropTick,
    input  logic                      placeStrobe,
    input  blocks_pkg::cellCode       placeType,
    input  blocks_pkg::shapeRow [0:3] placeShape,
    output logic                      pieceLocked,
    output blocks_pkg::boardRow       fullBoard [0:`BOARD_ROWS-1]
);

    typedef logic [0:`BOARD_COLS-1] occRow;

    occRow               movOcc    [0:`BOARD_ROWS-1];
    occRow               stackOcc  [0:`BOARD_ROWS-1];
    blocks_pkg::boardRow stackCode [0:`BOARD_ROWS-1];
    blocks_pkg::cellCode movType;

    occRow shifted [0:`BOARD_ROWS-1];
    occRow landed  [0:`BOARD_ROWS-1];

    logic leftQ;
    logic rightQ;
    logic leftLatch;
    logic rightLatch;
    logic moveLeft;
    logic moveRight;
    logic shiftOk;
    logic lockNow;
    logic tickNow;

    // a placement swallows a tick in the same cycle
    assign tickNow   = dropTick & ~placeStrobe;
    assign moveLeft  = leftLatch & ~rightLatch;
    assign moveRight = rightLatch & ~leftLatch;

    always_comb begin
        shiftOk = moveLeft | moveRight;
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            if (moveLeft) begin
                shifted[r] = movOcc[r] << 1;
                if (movOcc[r][0]) begin
                    shiftOk = 1'b0;
                end
            end else begin
                shifted[r] = movOcc[r] >> 1;
                if (movOcc[r][`BOARD_COLS-1]) begin
                    shiftOk = 1'b0;
                end
            end
            if (|(shifted[r] & stackOcc[r])) begin
                shiftOk = 1'b0;
            end
        end

        // collisions are judged after the sideways move
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            landed[r] = shiftOk ? shifted[r] : movOcc[r];
        end
        lockNow = |landed[`BOARD_ROWS-1];
        for (int r = 0; r < `BOARD_ROWS - 1; r++) begin
            if (|(landed[r] & stackOcc[r+1])) begin
                lockNow = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            leftQ       <= 1'b0;
            rightQ      <= 1'b0;
            leftLatch   <= 1'b0;
            rightLatch  <= 1'b0;
            pieceLocked <= 1'b0;
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                movOcc[r]   <= '0;
                stackOcc[r] <= '0;
            end
        end else begin
            leftQ       <= left;
            rightQ      <= right;
            pieceLocked <= tickNow & lockNow;

            // a fresh edge survives the tick that clears the latches
            if (tickNow) begin
                leftLatch  <= 1'b0;
                rightLatch <= 1'b0;
            end
            if (left && !leftQ) begin
                leftLatch <= 1'b1;
            end
            if (right && !rightQ) begin
                rightLatch <= 1'b1;
            end

            if (placeStrobe) begin
                for (int r = 0; r < `BOARD_ROWS; r++) begin
                    movOcc[r] <= '0;
                end
                for (int i = 0; i < 4; i++) begin
                    movOcc[i][`SPAWN_COL +: 4] <= placeShape[i];
                end
            end else if (tickNow) begin
                if (lockNow) begin
                    for (int r = 0; r < `BOARD_ROWS; r++) begin
                        stackOcc[r] <= stackOcc[r] | landed[r];
                        movOcc[r]   <= '0;
                    end
                end else begin
                    movOcc[0] <= '0;
                    for (int r = 1; r < `BOARD_ROWS; r++) begin
                        movOcc[r] <= landed[r-1];
                    end
                end
            end
        end
    end

    // codes only count where the matching occupancy bit is set
    always_ff @(posedge clk) begin
        if (placeStrobe) begin
            movType <= placeType;
        end else if (tickNow && lockNow) begin
            for (int r = 0; r < `BOARD_ROWS; r++) begin
                for (int c = 0; c < `BOARD_COLS; c++) begin
                    if (landed[r][c]) begin
                        stackCode[r][c] <= movType;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            for (int c = 0; c < `BOARD_COLS; c++) begin
                fullBoard[r][c] = (movOcc[r][c] ? movType : 4'd0)
                                | (stackOcc[r][c] ? stackCode[r][c] : 4'd0);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/cellColorizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "blocks_params.svh"

module cellColorizer (
    input  blocks_pkg::boardRow fullBoard   [0:`BOARD_ROWS-1],
    output blocks_pkg::colorRow colorValues [0:`BOARD_ROWS-1]
);

    always_comb begin
        for (int r = 0; r < `BOARD_ROWS; r++) begin
            for (int c = 0; c < `BOARD_COLS; c++) begin
                // codes past the table show as black
                if (fullBoard[r][c] <= 4'd8) begin
                    colorValues[r][c] = blocks_pkg::pieceColors[fullBoard[r][c]];
                end else begin
                    colorValues[r][c] = blocks_pkg::pieceColors[0];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/dropTicker.sv
`timescale 1ns/100ps
`default_nettype none

`include "blocks_params.svh"

module dropTicker (
    input  logic clk,
    input  logic arstN,
    output logic dropTick
);

    localparam int countWidth = $clog2(`DROP_PERIOD);
    localparam logic [countWidth-1:0] lastCount = countWidth'(`DROP_PERIOD - 1);

    logic [countWidth-1:0] count;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            dropTick <= 1'b0;
        end else begin
            // pulse on the wrap, free running
            dropTick <= (count == lastCount);
            if (count == lastCount) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/pieceFetcher.sv
`timescale 1ns/100ps
`default_nettype none

module pieceFetcher (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     spawnReq,
    output logic                     spawnAck,
    output logic [4:0]               romAddr,
    input  blocks_pkg::shapeRow      romData,
    output logic                     placeStrobe,
    output blocks_pkg::cellCode      placeType,
    output blocks_pkg::shapeRow [0:3] placeShape
);

    blocks_pkg::fetchState state;
    logic [1:0]            rowIdx;
    blocks_pkg::cellCode   nextType;

    assign romAddr   = {nextType[2:0], rowIdx};
    assign placeType = nextType;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= blocks_pkg::idle;
            rowIdx      <= 2'd0;
            spawnAck    <= 1'b0;
            placeStrobe <= 1'b0;
            nextType    <= 4'd1;
        end else begin
            placeStrobe <= 1'b0;
            case (state)
                blocks_pkg::idle: begin
                    if (spawnReq) begin
                        state  <= blocks_pkg::readRows;
                        rowIdx <= 2'd0;
                    end
                end
                blocks_pkg::readRows: begin
                    rowIdx <= rowIdx + 2'd1;
                    if (rowIdx == 2'd3) begin
                        state <= blocks_pkg::place;
                    end
                end
                blocks_pkg::place: begin
                    placeStrobe <= 1'b1;
                    state       <= blocks_pkg::acked;
                end
                blocks_pkg::acked: begin
                    // piece lands with the strobe, so ack follows it
                    if (placeStrobe) begin
                        spawnAck <= 1'b1;
                        nextType <= (nextType == 4'd7) ? 4'd1 : nextType + 4'd1;
                    end else if (!spawnReq) begin
                        spawnAck <= 1'b0;
                        state    <= blocks_pkg::idle;
                    end
                end
                default: state <= blocks_pkg::idle;
            endcase
        end
    end

    // rom data trails its address by one cycle
    always_ff @(posedge clk) begin
        if (state == blocks_pkg::readRows && rowIdx != 2'd0) begin
            placeShape[rowIdx - 2'd1] <= romData;
        end else if (state == blocks_pkg::place) begin
            placeShape[3] <= romData;
        end
    end

endmodule

`default_nettype wire

// File: verilog/shapeRom.sv
`timescale 1ns/100ps
`default_nettype none

module shapeRom (
    input  logic                clk,
    input  logic [4:0]          romAddr,
    output blocks_pkg::shapeRow romData
);

    // address is {type, row}, rows not listed are empty
    always_ff @(posedge clk) begin
        case (romAddr)
            // T
            5'b001_00: romData <= 4'b1110;
            5'b001_01: romData <= 4'b0100;
            // O
            5'b010_00: romData <= 4'b0110;
            5'b010_01: romData <= 4'b0110;
            // J
            5'b011_00: romData <= 4'b1000;
            5'b011_01: romData <= 4'b1110;
            // L
            5'b100_00: romData <= 4'b0010;
            5'b100_01: romData <= 4'b1110;
            // Z
            5'b101_00: romData <= 4'b1100;
            5'b101_01: romData <= 4'b0110;
            // S
            5'b110_00: romData <= 4'b0110;
            5'b110_01: romData <= 4'b1100;
            // I lies flat in the top row
            5'b111_00: romData <= 4'b1111;
            default:   romData <= 4'b0000;
        endcase
    end

endmodule

`default_nettype wire
